/* hdl/clkPkg.sv */
`default_nettype none

package clkPkg;

  // Diagnostic function code, group in the top 4 bits
  localparam int DIAG_FUNC_W = 7;
  localparam int FUNC_SEL_W = 3;

  // Diagnostic data covers EBUS bits 30..35, bit 35 is the LSB
  localparam int DIAG_DATA_W = 6;

  // Burst counter loads one nibble at a time
  localparam int BURST_W = 8;
  localparam int NIBBLE_W = 4;

  // CRAM time field
  localparam int TIME_W = 2;

  // Bit positions in diagData for the load functions
  localparam int DATA_CTL_DIS = 0;      // EBUS 35
  localparam int DATA_EDP_DIS = 1;      // EBUS 34
  localparam int DATA_CRM_DIS = 2;      // EBUS 33
  localparam int DATA_MBOX_CYC_DIS = 3; // EBUS 32

  typedef enum logic [3:0] {
    GRP_CTL  = 4'd0,
    GRP_LOAD = 4'd4,
    GRP_READ = 4'd8
  } diagGroupE;

  // Ctl functions 00x
  typedef enum logic [2:0] {
    CTL_STOP        = 3'd0,
    CTL_START       = 3'd1,
    CTL_SINGLE_STEP = 3'd2,
    CTL_EBOX_SS     = 3'd3,
    CTL_COND_SS     = 3'd4,
    CTL_BURST       = 3'd5,
    CTL_CLR_RESET   = 3'd6,
    CTL_SET_RESET   = 3'd7
  } ctlFuncE;

  // Load functions 04x, other codes do nothing
  typedef enum logic [2:0] {
    LD_BURST_LSB = 3'd2,
    LD_BURST_MSB = 3'd3,
    LD_RATE      = 3'd4,
    LD_EBOX_DIS  = 3'd5,
    LD_MBOX_CTL  = 3'd7
  } loadFuncE;

  typedef enum logic [1:0] {
    RS_IDLE,
    RS_RUN,
    RS_BURST,
    RS_STEP
  } runStateE;

endpackage

`default_nettype wire

/* hdl/clkFuncDecode.sv */
`default_nettype none

module clkFuncDecode (
  input  wire                             MBOX_CLK,
  input  wire                             CLK,
  input  wire                             diagStrobe,
  input  wire [clkPkg::DIAG_FUNC_W-1:0]   diagFunc,
  output logic                            ctlValid,
  output clkPkg::ctlFuncE                 ctlFunc,
  output logic                            loadValid,
  output clkPkg::loadFuncE                loadFunc
);

  clkPkg::diagGroupE funcGroup;
  logic [clkPkg::FUNC_SEL_W-1:0] funcSel;
  logic isCtl;
  logic isLoad;

  // Split the code into group and selector
  assign funcGroup = clkPkg::diagGroupE'(diagFunc[clkPkg::DIAG_FUNC_W-1:clkPkg::FUNC_SEL_W]);
  assign funcSel = diagFunc[clkPkg::FUNC_SEL_W-1:0];

  // Read group (10x) is handled combinationally elsewhere
  assign isCtl = diagStrobe && (funcGroup == clkPkg::GRP_CTL);
  assign isLoad = diagStrobe && (funcGroup == clkPkg::GRP_LOAD);

  // One pulse per strobe, one cycle after it
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      ctlValid <= 1'b0;
      loadValid <= 1'b0;
    end else begin
      ctlValid <= isCtl;
      loadValid <= isLoad;
    end
  end

  // Selector captured with the strobe
  // Only qualified by the matching valid downstream
  always_ff @(posedge MBOX_CLK) begin
    if (diagStrobe) begin
      ctlFunc <= clkPkg::ctlFuncE'(funcSel);
      loadFunc <= clkPkg::loadFuncE'(funcSel);
    end
  end

  // A strobe lands in at most one of the two function paths
  aOneFuncPath: assert property (
    @(posedge MBOX_CLK) disable iff (CLK)
    !(ctlValid && loadValid)
  );

endmodule

`default_nettype wire

/* hdl/clkConfigRegs.sv */
`default_nettype none

module clkConfigRegs #(
  parameter int RATE_W = 2
) (
  input  wire                             MBOX_CLK,
  input  wire                             CLK,
  input  wire                             loadValid,
  input  wire clkPkg::loadFuncE           loadFunc,
  input  wire [clkPkg::DIAG_DATA_W-1:0]   diagData,
  output logic [RATE_W-1:0]               rateSel,
  output logic                            crmDis,
  output logic                            edpDis,
  output logic                            ctlDis,
  output logic                            mboxCycleDis
);

  // Board configuration, cleared by reset
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      rateSel <= '0;
      crmDis <= 1'b0;
      edpDis <= 1'b0;
      ctlDis <= 1'b0;
      mboxCycleDis <= 1'b0;
    end else if (loadValid) begin
      case (loadFunc)
        // 044 rate select in the low data bits
        clkPkg::LD_RATE: rateSel <= diagData[RATE_W-1:0];
        // 045 EBOX section clock disables, EBUS 33..35
        clkPkg::LD_EBOX_DIS: begin
          crmDis <= diagData[clkPkg::DATA_CRM_DIS];
          edpDis <= diagData[clkPkg::DATA_EDP_DIS];
          ctlDis <= diagData[clkPkg::DATA_CTL_DIS];
        end
        // 047 MBOX cycle disable on EBUS 32
        clkPkg::LD_MBOX_CTL: mboxCycleDis <= diagData[clkPkg::DATA_MBOX_CYC_DIS];
        // Burst nibbles belong to the run control
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/clkRunCtl.sv */
`default_nettype none

module clkRunCtl #(
  parameter int RATE_W = 2
) (
  input  wire                             MBOX_CLK,
  input  wire                             CLK,
  input  wire                             ctlValid,
  input  wire clkPkg::ctlFuncE            ctlFunc,
  input  wire                             loadValid,
  input  wire clkPkg::loadFuncE           loadFunc,
  input  wire [clkPkg::DIAG_DATA_W-1:0]   diagData,
  input  wire [RATE_W-1:0]                rateSel,
  input  wire                             mboxCycleDis,
  output logic                            mboxTick,
  output clkPkg::runStateE                runState,
  output logic [clkPkg::BURST_W-1:0]      burstCount,
  output logic                            mrReset
);

  // Divider wide enough for the largest rate select
  localparam int DIV_W = (1 << RATE_W) - 1;

  logic [DIV_W-1:0] divCount;
  logic [DIV_W-1:0] divMask;
  logic rateTick;
  logic burstEmpty;
  logic tickGo;
  clkPkg::runStateE nextState;

  // Free-running divider, never reset by the run state
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      divCount <= '0;
    end else begin
      divCount <= divCount + 1'b1;
    end
  end

  // Low rateSel bits all zero gives one tick per 2^rateSel cycles
  assign divMask = ~({DIV_W{1'b1}} << rateSel);
  assign rateTick = (divCount & divMask) == '0;

  assign burstEmpty = burstCount == '0;

  // Burst with an empty counter ends without a tick
  assign tickGo = rateTick && (runState != clkPkg::RS_IDLE) &&
                  !((runState == clkPkg::RS_BURST) && burstEmpty);

  always_comb begin
    nextState = runState;
    // Step and burst finish on their own
    if (rateTick) begin
      case (runState)
        clkPkg::RS_STEP: nextState = clkPkg::RS_IDLE;
        clkPkg::RS_BURST: begin
          if (burstCount <= clkPkg::BURST_W'(1)) nextState = clkPkg::RS_IDLE;
        end
        default: ;
      endcase
    end
    // Ctl functions override
    if (ctlValid) begin
      case (ctlFunc)
        clkPkg::CTL_STOP:        nextState = clkPkg::RS_IDLE;
        clkPkg::CTL_START:       nextState = clkPkg::RS_RUN;
        clkPkg::CTL_SINGLE_STEP: nextState = clkPkg::RS_STEP;
        clkPkg::CTL_BURST:       nextState = clkPkg::RS_BURST;
        // EBOX and conditional single step are not modelled
        clkPkg::CTL_EBOX_SS, clkPkg::CTL_COND_SS: ;
        default: ;
      endcase
    end
  end

  // State and tick registered on the same edge
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      runState <= clkPkg::RS_IDLE;
      mboxTick <= 1'b0;
    end else begin
      runState <= nextState;
      // MBOX cycle disable only hides the tick
      mboxTick <= tickGo && !mboxCycleDis;
    end
  end

  // Burst counter, nibble loads win over the count down
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      burstCount <= '0;
    end else if (loadValid && (loadFunc == clkPkg::LD_BURST_LSB)) begin
      burstCount[clkPkg::NIBBLE_W-1:0] <= diagData[clkPkg::NIBBLE_W-1:0];
    end else if (loadValid && (loadFunc == clkPkg::LD_BURST_MSB)) begin
      burstCount[clkPkg::BURST_W-1:clkPkg::NIBBLE_W] <= diagData[clkPkg::NIBBLE_W-1:0];
    end else if ((runState == clkPkg::RS_BURST) && rateTick && !burstEmpty) begin
      burstCount <= burstCount - 1'b1;
    end
  end

  // Master reset held from power-up until cleared
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      mrReset <= 1'b1;
    end else if (ctlValid && (ctlFunc == clkPkg::CTL_CLR_RESET)) begin
      mrReset <= 1'b0;
    end else if (ctlValid && (ctlFunc == clkPkg::CTL_SET_RESET)) begin
      mrReset <= 1'b1;
    end
  end

  // Every tick was decided in a running state
  aNoTickFromIdle: assert property (
    @(posedge MBOX_CLK) disable iff (CLK)
    mboxTick |-> ($past(runState) != clkPkg::RS_IDLE)
  );

endmodule

`default_nettype wire

/* hdl/clkSyncDetect.sv */
`default_nettype none

module clkSyncDetect (
  input  wire                          MBOX_CLK,
  input  wire                          CLK,
  input  wire                          mboxTick,
  input  wire [clkPkg::TIME_W-1:0]     cramTime,
  input  wire                          mboxWait,
  input  wire                          mboxResp,
  input  wire                          crmDis,
  input  wire                          edpDis,
  input  wire                          ctlDis,
  output logic                         eboxSync,
  output logic                         eboxClkEn,
  output logic                         crmClkEn,
  output logic                         edpClkEn,
  output logic                         ctlClkEn
);

  // MBOX clock phase within the current EBOX cycle
  logic [clkPkg::TIME_W-1:0] phaseCount;
  logic mboxGo;
  logic phaseMatch;

  // EBOX may proceed unless waiting on a memory response
  assign mboxGo = !mboxWait || mboxResp;
  assign phaseMatch = phaseCount == cramTime;

  // Armed sync fires on the next tick
  assign eboxClkEn = mboxTick && eboxSync;

  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      phaseCount <= '0;
      eboxSync <= 1'b0;
    end else if (mboxTick) begin
      if (eboxClkEn) begin
        // New EBOX cycle starts at phase zero
        phaseCount <= '0;
        eboxSync <= 1'b0;
      end else if (mboxGo) begin
        if (phaseMatch) begin
          eboxSync <= 1'b1;
        end else begin
          phaseCount <= phaseCount + 1'b1;
        end
      end
      // Waiting holds the phase, no sync
    end
  end

  // Per-section enables
  assign crmClkEn = eboxClkEn && !crmDis;
  assign edpClkEn = eboxClkEn && !edpDis;
  assign ctlClkEn = eboxClkEn && !ctlDis;

  // EBOX clock only on an MBOX tick, and it consumes the sync
  aClkEnOnTick: assert property (
    @(posedge MBOX_CLK) disable iff (CLK)
    eboxClkEn |-> mboxTick ##1 !eboxSync
  );

endmodule

`default_nettype wire

/* hdl/clkDiagRead.sv */
`default_nettype none

module clkDiagRead #(
  parameter int RATE_W = 2
) (
  input  wire [clkPkg::DIAG_FUNC_W-1:0]  diagFunc,
  input  wire clkPkg::runStateE          runState,
  input  wire [clkPkg::BURST_W-1:0]      burstCount,
  input  wire                            mrReset,
  input  wire                            eboxSync,
  input  wire [RATE_W-1:0]               rateSel,
  input  wire                            crmDis,
  input  wire                            edpDis,
  input  wire                            ctlDis,
  input  wire                            mboxCycleDis,
  output logic [clkPkg::DIAG_DATA_W-1:0] diagRdData
);

  clkPkg::diagGroupE funcGroup;
  logic [clkPkg::FUNC_SEL_W-1:0] funcSel;

  assign funcGroup = clkPkg::diagGroupE'(diagFunc[clkPkg::DIAG_FUNC_W-1:clkPkg::FUNC_SEL_W]);
  assign funcSel = diagFunc[clkPkg::FUNC_SEL_W-1:0];

  // Level read path, zero outside the 10x group
  always_comb begin
    diagRdData = '0;
    if (funcGroup == clkPkg::GRP_READ) begin
      case (funcSel)
        // Burst counter high bits
        3'd0: diagRdData = burstCount[clkPkg::BURST_W-1 -: clkPkg::DIAG_DATA_W];
        // Remaining low bits, left justified
        3'd1: diagRdData = {burstCount[clkPkg::BURST_W-clkPkg::DIAG_DATA_W-1:0], 4'b0000};
        3'd2: diagRdData = {runState, mrReset, eboxSync, 2'b00};
        3'd3: diagRdData[RATE_W-1:0] = rateSel;
        3'd4: diagRdData = {crmDis, edpDis, ctlDis, mboxCycleDis, 2'b00};
        default: diagRdData = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/clkTop.sv */
`default_nettype none

module clkTop #(
  parameter int RATE_W = 2
) (
  input  wire                             MBOX_CLK,
  input  wire                             CLK,
  input  wire                             diagStrobe,
  input  wire [clkPkg::DIAG_FUNC_W-1:0]   diagFunc,
  input  wire [clkPkg::DIAG_DATA_W-1:0]   diagData,
  input  wire [clkPkg::TIME_W-1:0]        cramTime,
  input  wire                             mboxWait,
  input  wire                             mboxResp,
  output logic [clkPkg::DIAG_DATA_W-1:0]  diagRdData,
  output logic                            mboxTick,
  output logic                            eboxSync,
  output logic                            eboxClkEn,
  output logic                            crmClkEn,
  output logic                            edpClkEn,
  output logic                            ctlClkEn,
  output logic                            mrReset
);

  // Decoded function pulses
  logic ctlValid;
  logic loadValid;
  clkPkg::ctlFuncE ctlFunc;
  clkPkg::loadFuncE loadFunc;

  // Configuration
  logic [RATE_W-1:0] rateSel;
  logic crmDis;
  logic edpDis;
  logic ctlDis;
  logic mboxCycleDis;

  // Run status
  clkPkg::runStateE runState;
  logic [clkPkg::BURST_W-1:0] burstCount;

  clkFuncDecode uFuncDecode (
    .MBOX_CLK   (MBOX_CLK),
    .CLK        (CLK),
    .diagStrobe (diagStrobe),
    .diagFunc   (diagFunc),
    .ctlValid   (ctlValid),
    .ctlFunc    (ctlFunc),
    .loadValid  (loadValid),
    .loadFunc   (loadFunc)
  );

  clkConfigRegs #(.RATE_W(RATE_W)) uConfigRegs (
    .MBOX_CLK     (MBOX_CLK),
    .CLK          (CLK),
    .loadValid    (loadValid),
    .loadFunc     (loadFunc),
    .diagData     (diagData),
    .rateSel      (rateSel),
    .crmDis       (crmDis),
    .edpDis       (edpDis),
    .ctlDis       (ctlDis),
    .mboxCycleDis (mboxCycleDis)
  );

  clkRunCtl #(.RATE_W(RATE_W)) uRunCtl (
    .MBOX_CLK     (MBOX_CLK),
    .CLK          (CLK),
    .ctlValid     (ctlValid),
    .ctlFunc      (ctlFunc),
    .loadValid    (loadValid),
    .loadFunc     (loadFunc),
    .diagData     (diagData),
    .rateSel      (rateSel),
    .mboxCycleDis (mboxCycleDis),
    .mboxTick     (mboxTick),
    .runState     (runState),
    .burstCount   (burstCount),
    .mrReset      (mrReset)
  );

  clkSyncDetect uSyncDetect (
    .MBOX_CLK  (MBOX_CLK),
    .CLK       (CLK),
    .mboxTick  (mboxTick),
    .cramTime  (cramTime),
    .mboxWait  (mboxWait),
    .mboxResp  (mboxResp),
    .crmDis    (crmDis),
    .edpDis    (edpDis),
    .ctlDis    (ctlDis),
    .eboxSync  (eboxSync),
    .eboxClkEn (eboxClkEn),
    .crmClkEn  (crmClkEn),
    .edpClkEn  (edpClkEn),
    .ctlClkEn  (ctlClkEn)
  );

  clkDiagRead #(.RATE_W(RATE_W)) uDiagRead (
    .diagFunc     (diagFunc),
    .runState     (runState),
    .burstCount   (burstCount),
    .mrReset      (mrReset),
    .eboxSync     (eboxSync),
    .rateSel      (rateSel),
    .crmDis       (crmDis),
    .edpDis       (edpDis),
    .ctlDis       (ctlDis),
    .mboxCycleDis (mboxCycleDis),
    .diagRdData   (diagRdData)
  );

endmodule

`default_nettype wire

/* tb/clkTb.sv */
`default_nettype none

module clkTb;
  timeunit 1ns;
  timeprecision 100ps;

  logic MBOX_CLK;
  logic CLK;
  logic diagStrobe;
  logic [clkPkg::DIAG_FUNC_W-1:0] diagFunc;
  logic [clkPkg::DIAG_DATA_W-1:0] diagData;
  logic [clkPkg::TIME_W-1:0] cramTime;
  logic mboxWait;
  logic mboxResp;
  wire [clkPkg::DIAG_DATA_W-1:0] diagRdData;
  wire mboxTick;
  wire eboxSync;
  wire eboxClkEn;
  wire crmClkEn;
  wire edpClkEn;
  wire ctlClkEn;
  wire mrReset;
  int errCount;
  int timeoutCount;

  clkTop #(.RATE_W(2)) UUT (.*);

  // 8 ns MBOX clock
  initial begin
    MBOX_CLK = 1'b0;
    forever #4 MBOX_CLK = ~MBOX_CLK;
  end

  // Drive point, 1 ns after the rising edge
  task automatic nextCycle();
    @(posedge MBOX_CLK);
    #1;
  endtask

  task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errCount++;
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  // One strobe, returns once the target registers have updated
  task automatic doFunc(input logic [3:0] grp, input logic [2:0] sel, input logic [5:0] data);
    nextCycle();
    diagFunc = {grp, sel};
    diagData = data;
    diagStrobe = 1'b1;
    nextCycle();
    diagStrobe = 1'b0;
    nextCycle();
  endtask

  // Read path is a level, sampled 1 ns after the code is set
  task automatic readDiag(input logic [2:0] sel, output logic [5:0] data);
    nextCycle();
    diagFunc = {clkPkg::GRP_READ, sel};
    #1;
    data = diagRdData;
  endtask

  task automatic countPulses(input int cycles, output int ticks, output int clkEns);
    ticks = 0;
    clkEns = 0;
    repeat (cycles) begin
      nextCycle();
      if (mboxTick) ticks++;
      if (eboxClkEn) clkEns++;
    end
  endtask

  // Waits for a tick or an EBOX clock enable, counting ticks on the way
  task automatic waitPulse(input bit onClkEn, input int limit, output int ticks);
    int n;
    n = 0;
    ticks = 0;
    do begin
      nextCycle();
      n++;
      if (mboxTick) ticks++;
    end while (!(onClkEn ? eboxClkEn : mboxTick) && n < limit);
    if (!(onClkEn ? eboxClkEn : mboxTick)) begin
      timeoutCount++;
      $display("Timeout at %0t: no %s within %0d cycles", $time,
               onClkEn ? "eboxClkEn" : "mboxTick", limit);
    end
  endtask

  task automatic resetAndConfig();
    logic [5:0] rd;
    logic [1:0] rate;
    checkVal("mrReset", mrReset, 1);
    checkVal("tick/sync/enables", {mboxTick, eboxSync, eboxClkEn, crmClkEn, edpClkEn,
             ctlClkEn}, 0);
    // Only mrReset shows in the status words after reset
    for (int s = 0; s < 8; s++) begin
      readDiag(s[2:0], rd);
      checkVal($sformatf("diagRdData sel %0d", s), rd, (s == 2) ? 6'b001000 : 6'b000000);
    end
    rate = 2'($urandom_range(3, 1));
    doFunc(clkPkg::GRP_LOAD, clkPkg::LD_RATE, {4'b0000, rate});
    readDiag(3'd3, rd);
    checkVal("rateSel", rd, rate);
    // Data bit 2 crm, bit 1 edp, bit 0 ctl
    doFunc(clkPkg::GRP_LOAD, clkPkg::LD_EBOX_DIS, 6'b000101);
    readDiag(3'd4, rd);
    checkVal("crm/edp/ctl disables", rd, 6'b101000);
    // MBOX cycle disable on data bit 3
    doFunc(clkPkg::GRP_LOAD, clkPkg::LD_MBOX_CTL, 6'b001000);
    readDiag(3'd4, rd);
    checkVal("mboxCycleDis", rd, 6'b101100);
    doFunc(clkPkg::GRP_LOAD, clkPkg::LD_EBOX_DIS, 6'b000010);
    doFunc(clkPkg::GRP_LOAD, clkPkg::LD_MBOX_CTL, 6'b000000);
    readDiag(3'd4, rd);
    checkVal("edpDis alone", rd, 6'b010000);
    doFunc(clkPkg::GRP_LOAD, clkPkg::LD_EBOX_DIS, 6'b000000);
  endtask

  task automatic masterReset();
    logic [5:0] rd;
    for (int i = 0; i < 2; i++) begin
      doFunc(clkPkg::GRP_CTL, (i == 0) ? clkPkg::CTL_CLR_RESET : clkPkg::CTL_SET_RESET, 6'd0);
      readDiag(3'd2, rd);
      checkVal("mrReset", mrReset, i);
      checkVal("sel 2 mrReset bit", rd[3], i);
    end
  endtask

  task automatic rateSelect();
    int ticks;
    int clkEns;
    for (int r = 0; r < 4; r++) begin
      doFunc(clkPkg::GRP_LOAD, clkPkg::LD_RATE, 6'(r));
      doFunc(clkPkg::GRP_CTL, clkPkg::CTL_START, 6'd0);
      // Window opens on the first tick
      waitPulse(1'b0, 16, ticks);
      countPulses(63, ticks, clkEns);
      checkVal($sformatf("mboxTick count rate %0d", r), ticks + 1, 64 >> r);
      doFunc(clkPkg::GRP_CTL, clkPkg::CTL_STOP, 6'd0);
      countPulses(32, ticks, clkEns);
      checkVal("mboxTick after stop", ticks, 0);
    end
    doFunc(clkPkg::GRP_LOAD, clkPkg::LD_RATE, 6'd0);
  endtask

  task automatic burstRun();
    logic [5:0] rd0;
    logic [5:0] rd1;
    int n;
    int ticks;
    int clkEns;
    for (int i = 0; i < 4; i++) begin
      // Last pass is an empty burst
      n = (i == 3) ? 0 : $urandom_range(40, 1);
      doFunc(clkPkg::GRP_LOAD, clkPkg::LD_BURST_LSB, 6'(n % 16));
      doFunc(clkPkg::GRP_LOAD, clkPkg::LD_BURST_MSB, 6'(n / 16));
      readDiag(3'd0, rd0);
      readDiag(3'd1, rd1);
      checkVal("burstCount loaded", {rd0, rd1[5:4]}, n);
      doFunc(clkPkg::GRP_CTL, clkPkg::CTL_BURST, 6'd0);
      countPulses(n + 16, ticks, clkEns);
      checkVal($sformatf("mboxTick count burst %0d", n), ticks, n);
      readDiag(3'd2, rd0);
      checkVal("runState after burst", rd0[5:4], 2'(clkPkg::RS_IDLE));
      readDiag(3'd0, rd0);
      readDiag(3'd1, rd1);
      checkVal("burstCount after burst", {rd0, rd1[5:4]}, 0);
    end
  endtask

  task automatic stepAndCycleDisable();
    logic [5:0] rd;
    int ticks;
    int clkEns;
    doFunc(clkPkg::GRP_CTL, clkPkg::CTL_SINGLE_STEP, 6'd0);
    countPulses(16, ticks, clkEns);
    checkVal("mboxTick per single step", ticks, 1);
    // Run with the tick hidden
    doFunc(clkPkg::GRP_LOAD, clkPkg::LD_MBOX_CTL, 6'b001000);
    doFunc(clkPkg::GRP_CTL, clkPkg::CTL_START, 6'd0);
    countPulses(32, ticks, clkEns);
    checkVal("mboxTick with mboxCycleDis", ticks, 0);
    readDiag(3'd2, rd);
    checkVal("runState with mboxCycleDis", rd[5:4], 2'(clkPkg::RS_RUN));
    doFunc(clkPkg::GRP_CTL, clkPkg::CTL_STOP, 6'd0);
    doFunc(clkPkg::GRP_LOAD, clkPkg::LD_MBOX_CTL, 6'd0);
  endtask

  task automatic eboxSyncTiming();
    logic [1:0] t;
    int ticks;
    int clkEns;
    t = 2'($urandom_range(3, 0));
    cramTime = t;
    doFunc(clkPkg::GRP_CTL, clkPkg::CTL_START, 6'd0);
    waitPulse(1'b1, 40, ticks);
    repeat (3) begin
      waitPulse(1'b1, 40, ticks);
      checkVal($sformatf("ticks between eboxClkEn time %0d", t), ticks, t + 2);
      // The enable only fires on an armed sync
      checkVal("eboxSync with eboxClkEn", eboxSync, 1);
    end
    // Wait raised in the enable cycle, so the next EBOX cycle stalls
    mboxWait = 1'b1;
    countPulses(40, ticks, clkEns);
    checkVal("eboxClkEn while waiting", clkEns, 0);
    checkVal("eboxSync while waiting", eboxSync, 0);
    mboxResp = 1'b1;
    waitPulse(1'b1, 40, ticks);
    mboxWait = 1'b0;
    mboxResp = 1'b0;
    // Each disable masks only its own section
    for (int d = 0; d < 3; d++) begin
      doFunc(clkPkg::GRP_LOAD, clkPkg::LD_EBOX_DIS, 6'(1 << d));
      waitPulse(1'b1, 40, ticks);
      checkVal("ctlClkEn", ctlClkEn, d != 0);
      checkVal("edpClkEn", edpClkEn, d != 1);
      checkVal("crmClkEn", crmClkEn, d != 2);
    end
    doFunc(clkPkg::GRP_LOAD, clkPkg::LD_EBOX_DIS, 6'd0);
    doFunc(clkPkg::GRP_CTL, clkPkg::CTL_STOP, 6'd0);
  endtask

  initial begin
    errCount = 0;
    timeoutCount = 0;
    void'($urandom(32'hb61fe076));
    CLK = 1'b1;
    diagStrobe = 1'b0;
    diagFunc = '0;
    diagData = '0;
    cramTime = '0;
    mboxWait = 1'b0;
    mboxResp = 1'b0;
    repeat (2) @(posedge MBOX_CLK);
    #1;
    CLK = 1'b0;
    resetAndConfig();
    masterReset();
    rateSelect();
    burstRun();
    stepAndCycleDisable();
    eboxSyncTiming();
    $display("Checks done: %0d value errors, %0d timeouts", errCount, timeoutCount);
    if (errCount == 0 && timeoutCount == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
hdl/clkPkg.sv
hdl/clkFuncDecode.sv
hdl/clkConfigRegs.sv
hdl/clkRunCtl.sv
hdl/clkSyncDetect.sv
hdl/clkDiagRead.sv
hdl/clkTop.sv
tb/clkTb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module clkTb -Mdir obj_dir -o clkSim
	./obj_dir/clkSim > sim.log 2>&1 || true
	cat sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
